//--- hw/uart_pkg.sv
//**************************************************************************
// Serial line definitions: bit timing, counter widths and frame opcodes
//**************************************************************************

package uart_pkg;

	// Clocks per serial bit, no oversampling beyond this
	localparam int CLKS_PER_BIT = 16;

	// Bit period counter width
	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	// Last count of a full bit period
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	// Last count of half a bit, used to land in the middle of the start bit
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	// Start bit, eight data bits, stop bit
	localparam int FRAME_W = 10;
	localparam logic [3:0] FRAME_LAST = 4'(FRAME_W - 1);

	// First byte of every host frame
	typedef enum logic [7:0] {
		OP_WRITE = 8'h57,
		OP_READ  = 8'h52
	} op_t;

endpackage

//--- hw/tap_pkg.sv
//**************************************************************************
// Register bus map, widths and the structs shared by the tap control path
//**************************************************************************

package tap_pkg;

	// Bus and tap widths
	localparam int ADDR_W = 8;
	localparam int DATA_W = 16;
	localparam int TAP_W  = 5;

	// Board configuration word
	localparam int CFG_W = 4;

	// Register map
	typedef enum logic [ADDR_W-1:0] {
		REG_CTL_TARGET  = 8'd0,
		REG_DATA_TARGET = 8'd1,
		REG_CTL_TAP     = 8'd2,
		REG_DATA_TAP    = 8'd3,
		REG_CONFIG      = 8'd4
	} reg_addr_t;

	// One bus request, qualified by a separate valid strobe
	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// Current delay taps, standing in for the delay line value outputs
	typedef struct packed {
		logic [TAP_W-1:0] ctl;
		logic [TAP_W-1:0] data;
	} tap_state_t;

endpackage

//--- hw/uart_rx.sv
//**************************************************************************
// Serial receiver, samples each bit at its middle and emits one byte per frame
//**************************************************************************
`timescale 1ns/1ns

module uart_rx (
	input  logic       tx_clk,
	input  logic       reset,
	input  logic       rxd,
	output logic       rx_valid,
	output logic [7:0] rx_byte
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                  rx_state;
	logic                       rxd_meta;
	logic                       rxd_sync;
	logic                       rxd_prev;
	logic [uart_pkg::CNT_W-1:0] clk_cnt;
	logic [2:0]                 bit_cnt;
	logic [7:0]                 shift;

	// Two flops against metastability, a third one for the falling edge
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			rx_state <= RX_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (rx_state)
				RX_IDLE: begin
					// Falling edge marks a start bit
					if (rxd_prev && !rxd_sync) begin
						rx_state <= RX_START;
						clk_cnt  <= '0;
					end
				end
				RX_START: begin
					// Glitch check in the middle of the start bit
					if (clk_cnt == uart_pkg::HALF_LAST) begin
						clk_cnt  <= '0;
						bit_cnt  <= '0;
						rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (clk_cnt == uart_pkg::BIT_LAST) begin
						// LSB first
						shift   <= {rxd_sync, shift[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin
					// Low stop bit drops the frame
					if (clk_cnt == uart_pkg::BIT_LAST) begin
						rx_valid <= rxd_sync;
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// Shift register holds still until the next frame starts
	assign rx_byte = shift;

endmodule

//--- hw/uart_tx.sv
//**************************************************************************
// Serial transmitter, one byte per start strobe, busy while shifting
//**************************************************************************
`timescale 1ns/1ns

module uart_tx (
	input  logic       tx_clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       txd,
	output logic       tx_busy
);

	logic [uart_pkg::FRAME_W-1:0] frame;
	logic [uart_pkg::CNT_W-1:0]   clk_cnt;
	logic [3:0]                   bit_cnt;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			// All ones keeps the line idle high
			frame   <= '1;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_busy <= 1'b0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				// Stop bit, data LSB first, start bit at the bottom
				frame   <= {1'b1, tx_byte, 1'b0};
				clk_cnt <= '0;
				bit_cnt <= '0;
				tx_busy <= 1'b1;
			end
		end else if (clk_cnt == uart_pkg::BIT_LAST) begin
			clk_cnt <= '0;
			// Shift in ones so the line rests high afterwards
			frame   <= {1'b1, frame[uart_pkg::FRAME_W-1:1]};
			if (bit_cnt == uart_pkg::FRAME_LAST)
				tx_busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Line driven straight from a flop
	assign txd = frame[0];

endmodule

//--- hw/cmd_engine.sv
//**************************************************************************
// Host frame parser, issues bus requests and returns read data over serial
//**************************************************************************
`timescale 1ns/1ns

module cmd_engine (
	input  logic                      tx_clk,
	input  logic                      reset,
	input  logic                      rx_valid,
	input  logic [7:0]                rx_byte,
	input  logic                      tx_busy,
	input  logic [tap_pkg::DATA_W-1:0] rdata,
	output logic                      req_valid,
	output tap_pkg::bus_req_t         req,
	output logic                      tx_start,
	output logic [7:0]                tx_byte
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_DATA_HI,
		S_DATA_LO,
		S_WAIT_READ,
		S_SEND_HI,
		S_SEND_LO
	} state_t;

	state_t                    state;
	uart_pkg::op_t             op_q;
	logic [7:0]                data_hi;
	logic [7:0]                rd_lo;
	logic                      rd_pending;
	logic                      busy_q;
	logic                      busy_fall;

	// First idle cycle after a byte went out
	assign busy_fall = busy_q && !tx_busy;

	always_ff @(posedge tx_clk) begin
		if (reset) begin
			state      <= S_IDLE;
			req_valid  <= 1'b0;
			tx_start   <= 1'b0;
			rd_pending <= 1'b0;
			busy_q     <= 1'b0;
		end else begin
			req_valid  <= 1'b0;
			tx_start   <= 1'b0;
			busy_q     <= tx_busy;
			// Register read data lands one cycle after the request
			rd_pending <= req_valid && !req.we;
			case (state)
				S_IDLE: begin
					if (rx_valid) begin
						case (uart_pkg::op_t'(rx_byte))
							uart_pkg::OP_WRITE, uart_pkg::OP_READ: begin
								op_q  <= uart_pkg::op_t'(rx_byte);
								state <= S_ADDR;
							end
							// Unknown opcode, stay here and wait for a real one
							default: state <= S_IDLE;
						endcase
					end
				end
				S_ADDR: begin
					if (rx_valid) begin
						req.addr <= rx_byte;
						if (op_q == uart_pkg::OP_WRITE) begin
							state <= S_DATA_HI;
						end else begin
							req.we    <= 1'b0;
							req_valid <= 1'b1;
							state     <= S_WAIT_READ;
						end
					end
				end
				S_DATA_HI: begin
					if (rx_valid) begin
						data_hi <= rx_byte;
						state   <= S_DATA_LO;
					end
				end
				S_DATA_LO: begin
					if (rx_valid) begin
						req.we    <= 1'b1;
						req.wdata <= {data_hi, rx_byte};
						req_valid <= 1'b1;
						state     <= S_IDLE;
					end
				end
				S_WAIT_READ: begin
					// High byte goes out now, low byte kept for later
					if (rd_pending) begin
						tx_byte  <= rdata[15:8];
						rd_lo    <= rdata[7:0];
						tx_start <= 1'b1;
						state    <= S_SEND_HI;
					end
				end
				S_SEND_HI: begin
					if (busy_fall) begin
						tx_byte  <= rd_lo;
						tx_start <= 1'b1;
						state    <= S_SEND_LO;
					end
				end
				default: begin
					// Response done, accept frames again
					if (busy_fall)
						state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/tap_regs.sv
//**************************************************************************
// Delay control registers, two ramping tap lanes and the config word
//**************************************************************************
`timescale 1ns/1ns

module tap_regs (
	input  logic                       tx_clk,
	input  logic                       reset,
	input  logic                       req_valid,
	input  tap_pkg::bus_req_t          req,
	output logic [tap_pkg::DATA_W-1:0] rdata,
	output tap_pkg::tap_state_t        taps,
	output logic [tap_pkg::CFG_W-1:0]  ext_config
);

	logic [tap_pkg::TAP_W-1:0] ctl_target;
	logic [tap_pkg::TAP_W-1:0] data_target;
	tap_pkg::reg_addr_t        req_addr;

	assign req_addr = tap_pkg::reg_addr_t'(req.addr);

	// Writable registers, taps and unmapped addresses fall through
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			ctl_target  <= '0;
			data_target <= '0;
			ext_config  <= '0;
		end else if (req_valid && req.we) begin
			case (req_addr)
				tap_pkg::REG_CTL_TARGET:  ctl_target  <= req.wdata[tap_pkg::TAP_W-1:0];
				tap_pkg::REG_DATA_TARGET: data_target <= req.wdata[tap_pkg::TAP_W-1:0];
				tap_pkg::REG_CONFIG:      ext_config  <= req.wdata[tap_pkg::CFG_W-1:0];
				default: ;
			endcase
		end
	end

	// One tap per clock toward the target, like stepping a delay line
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			taps <= '0;
		end else begin
			if (taps.ctl < ctl_target)
				taps.ctl <= taps.ctl + 1'b1;
			else if (taps.ctl > ctl_target)
				taps.ctl <= taps.ctl - 1'b1;
			if (taps.data < data_target)
				taps.data <= taps.data + 1'b1;
			else if (taps.data > data_target)
				taps.data <= taps.data - 1'b1;
		end
	end

	// Registered read mux, value ready the cycle after the request
	always_ff @(posedge tx_clk) begin
		if (req_valid) begin
			case (req_addr)
				tap_pkg::REG_CTL_TARGET:  rdata <= tap_pkg::DATA_W'(ctl_target);
				tap_pkg::REG_DATA_TARGET: rdata <= tap_pkg::DATA_W'(data_target);
				tap_pkg::REG_CTL_TAP:     rdata <= tap_pkg::DATA_W'(taps.ctl);
				tap_pkg::REG_DATA_TAP:    rdata <= tap_pkg::DATA_W'(taps.data);
				tap_pkg::REG_CONFIG:      rdata <= tap_pkg::DATA_W'(ext_config);
				// Unmapped reads as zero
				default:                  rdata <= '0;
			endcase
		end
	end

endmodule

//--- hw/tap_ctrl_top.sv
//**************************************************************************
// Serial-controlled RGMII receive delay taps, joins UART, parser and registers
//**************************************************************************
`timescale 1ns/1ns

module tap_ctrl_top (
	input  logic                      tx_clk,
	input  logic                      reset,
	input  logic                      uart_rxd,
	output logic                      uart_txd,
	output tap_pkg::tap_state_t       taps,
	output logic [tap_pkg::CFG_W-1:0] ext_config,
	output logic                      vcxo_en
);

	logic                       rx_valid;
	logic [7:0]                 rx_byte;
	logic                       req_valid;
	tap_pkg::bus_req_t          req;
	logic [tap_pkg::DATA_W-1:0] rdata;
	logic                       tx_start;
	logic [7:0]                 tx_byte;
	logic                       tx_busy;

	uart_rx u_uart_rx (
		.tx_clk   (tx_clk),
		.reset    (reset),
		.rxd      (uart_rxd),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte)
	);

	cmd_engine u_cmd_engine (
		.tx_clk    (tx_clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.tx_busy   (tx_busy),
		.rdata     (rdata),
		.req_valid (req_valid),
		.req       (req),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte)
	);

	tap_regs u_tap_regs (
		.tx_clk     (tx_clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.rdata      (rdata),
		.taps       (taps),
		.ext_config (ext_config)
	);

	uart_tx u_uart_tx (
		.tx_clk   (tx_clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.txd      (uart_txd),
		.tx_busy  (tx_busy)
	);

	// Oscillator enable is active low on config bit 1
	assign vcxo_en = ~ext_config[1];

endmodule

//--- dv/tb_tap_ctrl.sv
//**************************************************************************
// Testbench for the serial tap control path, table-driven over the UART
//**************************************************************************
`timescale 1ns/1ns

module tb_tap_ctrl;

	localparam int CLK_PERIOD = 4;
	localparam int BIT_CLKS   = uart_pkg::CLKS_PER_BIT;
	// Serial time per table entry, six byte frames
	localparam int ENTRY_CLKS = 6 * 10 * BIT_CLKS;
	// Full tap range plus room for the request to land
	localparam int RAMP_MAX   = (1 << tap_pkg::TAP_W) + 2 * BIT_CLKS;
	// Neither a write nor a read opcode
	localparam logic [7:0] JUNK_OP = 8'h41;

	typedef enum logic [1:0] {
		K_WRITE,
		K_READ,
		K_JUNK_READ
	} kind_t;

	// Expected taps and config once an entry has settled
	typedef struct packed {
		logic [tap_pkg::TAP_W-1:0] ctl;
		logic [tap_pkg::TAP_W-1:0] data;
		logic [tap_pkg::CFG_W-1:0] cfg;
	} model_state_t;

	typedef struct packed {
		kind_t                      kind;
		logic [tap_pkg::ADDR_W-1:0] addr;
		logic [tap_pkg::DATA_W-1:0] data;
		logic [tap_pkg::DATA_W-1:0] exp_rd;
		model_state_t               exp_st;
	} entry_t;

	logic                      tx_clk;
	logic                      reset;
	logic                      uart_rxd;
	logic                      uart_txd;
	tap_pkg::tap_state_t       taps;
	logic [tap_pkg::CFG_W-1:0] ext_config;
	logic                      vcxo_en;

	entry_t       table_q[$];
	model_state_t model;
	logic [31:0]  lfsr;

	tap_ctrl_top u_tap_ctrl_top (
		.tx_clk     (tx_clk),
		.reset      (reset),
		.uart_rxd   (uart_rxd),
		.uart_txd   (uart_txd),
		.taps       (taps),
		.ext_config (ext_config),
		.vcxo_en    (vcxo_en)
	);

	always #(CLK_PERIOD / 2) tx_clk = ~tx_clk;

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bits(input int nbits, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val  = {val[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("TEST FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Targets keep 5 bits, config keeps 4, everything else ignores writes
	function automatic model_state_t model_write(input model_state_t st,
		input logic [7:0] addr, input logic [15:0] data);
		model_state_t nx;
		nx = st;
		case (addr)
			tap_pkg::REG_CTL_TARGET:  nx.ctl  = data[tap_pkg::TAP_W-1:0];
			tap_pkg::REG_DATA_TARGET: nx.data = data[tap_pkg::TAP_W-1:0];
			tap_pkg::REG_CONFIG:      nx.cfg  = data[tap_pkg::CFG_W-1:0];
			default: ;
		endcase
		return nx;
	endfunction

	// Reads go out only after the taps have settled on their targets
	function automatic logic [15:0] model_read(input model_state_t st, input logic [7:0] addr);
		case (addr)
			tap_pkg::REG_CTL_TARGET, tap_pkg::REG_CTL_TAP:   return 16'(st.ctl);
			tap_pkg::REG_DATA_TARGET, tap_pkg::REG_DATA_TAP: return 16'(st.data);
			tap_pkg::REG_CONFIG:                             return 16'(st.cfg);
			default:                                         return '0;
		endcase
	endfunction

	task automatic add_entry(input kind_t kind, input logic [7:0] addr, input logic [15:0] data);
		entry_t e;
		if (kind == K_WRITE)
			model = model_write(model, addr, data);
		e.kind   = kind;
		e.addr   = addr;
		e.data   = data;
		e.exp_rd = (kind == K_WRITE) ? 16'h0 : model_read(model, addr);
		e.exp_st = model;
		table_q.push_back(e);
	endtask

	task automatic add_random_write(input logic [7:0] addr);
		logic [15:0] val;
		take_bits(16, val);
		add_entry(K_WRITE, addr, val);
	endtask

	// Called on a falling edge, start bit, LSB first, stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rxd = frame[i];
			repeat (BIT_CLKS) @(negedge tx_clk);
		end
	endtask

	task automatic recv_byte(input string name, output logic [7:0] b);
		while (uart_txd !== 1'b0) @(negedge tx_clk);
		// Middle of the start bit, then one full bit per sample
		repeat (BIT_CLKS / 2) @(negedge tx_clk);
		check_val({name, " start bit"}, 32'd0, 32'(uart_txd));
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge tx_clk);
			b[i] = uart_txd;
		end
		repeat (BIT_CLKS) @(negedge tx_clk);
		check_val({name, " stop bit"}, 32'd1, 32'(uart_txd));
	endtask

	// Holding is fine, a single step toward the target cannot overshoot it
	function automatic logic step_ok(input logic [4:0] prev, input logic [4:0] cur,
		input logic [4:0] target);
		if (cur == prev)
			return 1'b1;
		else if (prev < target)
			return cur == prev + 5'd1;
		else if (prev > target)
			return cur == prev - 5'd1;
		else
			return 1'b0;
	endfunction

	task automatic check_ramp(input string name, input model_state_t st);
		tap_pkg::tap_state_t prev;
		int                  n;
		prev = taps;
		n    = 0;
		// At least one bit period so the write has landed before the exit test
		while (n < RAMP_MAX && (n < BIT_CLKS || taps.ctl != st.ctl || taps.data != st.data)) begin
			@(negedge tx_clk);
			check_val({name, " ctl step"}, 32'd1, 32'(step_ok(prev.ctl, taps.ctl, st.ctl)));
			check_val({name, " data step"}, 32'd1, 32'(step_ok(prev.data, taps.data, st.data)));
			prev = taps;
			n++;
		end
		check_val({name, " ctl tap"}, 32'(st.ctl), 32'(taps.ctl));
		check_val({name, " data tap"}, 32'(st.data), 32'(taps.data));
		check_val({name, " config"}, 32'(st.cfg), 32'(ext_config));
		check_val({name, " vcxo_en"}, 32'(!st.cfg[1]), 32'(vcxo_en));
	endtask

	task automatic run_entry(input int idx, input entry_t e);
		logic [7:0] hi;
		logic [7:0] lo;
		string      name;
		name = $sformatf("entry %0d", idx);
		if (e.kind == K_WRITE) begin
			send_byte(uart_pkg::OP_WRITE);
			send_byte(e.addr);
			send_byte(e.data[15:8]);
			send_byte(e.data[7:0]);
			check_ramp(name, e.exp_st);
		end else begin
			if (e.kind == K_JUNK_READ)
				send_byte(JUNK_OP);
			// Response may start before the last stop bit has been driven
			fork
				begin
					send_byte(uart_pkg::OP_READ);
					send_byte(e.addr);
				end
				begin
					recv_byte(name, hi);
					recv_byte(name, lo);
				end
			join
			check_val({name, " read"}, 32'(e.exp_rd), 32'({hi, lo}));
			// No stray byte after the response
			repeat (2 * 10 * BIT_CLKS) begin
				@(negedge tx_clk);
				check_val({name, " idle line"}, 32'd1, 32'(uart_txd));
			end
		end
	endtask

	initial begin
		tx_clk   = 1'b0;
		reset    = 1'b1;
		uart_rxd = 1'b1;
		lfsr     = 32'hcb3f_cf26;
		model    = '0;
		// Two ramp rounds with random targets, each read back
		for (int r = 0; r < 2; r++) begin
			add_random_write(tap_pkg::REG_CTL_TARGET);
			add_random_write(tap_pkg::REG_DATA_TARGET);
			add_entry(K_READ, tap_pkg::REG_CTL_TARGET, '0);
			add_entry(K_READ, tap_pkg::REG_DATA_TARGET, '0);
			add_entry(K_READ, tap_pkg::REG_CTL_TAP, '0);
			add_entry(K_READ, tap_pkg::REG_DATA_TAP, '0);
		end
		// Both lanes ramp down toward smaller targets
		add_entry(K_WRITE, tap_pkg::REG_CTL_TARGET, 16'h0003);
		add_entry(K_WRITE, tap_pkg::REG_DATA_TARGET, 16'h0001);
		// Config with bit 1 set, then cleared
		add_entry(K_WRITE, tap_pkg::REG_CONFIG, 16'hbeea);
		add_entry(K_READ, tap_pkg::REG_CONFIG, '0);
		add_entry(K_WRITE, tap_pkg::REG_CONFIG, 16'h0005);
		add_entry(K_READ, tap_pkg::REG_CONFIG, '0);
		add_entry(K_JUNK_READ, tap_pkg::REG_CTL_TARGET, '0);
		// Read-only and unmapped writes
		add_entry(K_WRITE, tap_pkg::REG_CTL_TAP, 16'h001f);
		add_entry(K_WRITE, 8'h07, 16'hffff);
		add_entry(K_WRITE, 8'hff, 16'h1234);
		add_entry(K_READ, 8'h05, '0);
		add_entry(K_READ, 8'hff, '0);
		add_entry(K_READ, tap_pkg::REG_DATA_TAP, '0);
		fork
			begin
				#((table_q.size() * ENTRY_CLKS * 4 + 64) * CLK_PERIOD);
				$display("Timed out waiting for the DUT to finish the test table");
				$display("TEST FAIL");
				$fatal(1, "Watchdog expired");
			end
		join_none
		repeat (8) @(negedge tx_clk);
		reset = 1'b0;
		@(negedge tx_clk);
		check_val("reset ctl tap", 32'd0, 32'(taps.ctl));
		check_val("reset data tap", 32'd0, 32'(taps.data));
		check_val("reset config", 32'd0, 32'(ext_config));
		check_val("reset vcxo_en", 32'd1, 32'(vcxo_en));
		check_val("reset txd", 32'd1, 32'(uart_txd));
		foreach (table_q[i])
			run_entry(i, table_q[i]);
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- flist.f
hw/uart_pkg.sv
hw/tap_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_engine.sv
hw/tap_regs.sv
hw/tap_ctrl_top.sv
dv/tb_tap_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the tap control testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_tap_ctrl -Mdir obj_dir -o sim_tap_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tap_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi
exit 0
